// File: compile.f
+incdir+include
+incdir+sim
hdl/soc_pkg.sv
hdl/bus_access.sv
hdl/system_decode.sv
hdl/bram.sv
hdl/led_port.sv
hdl/timer.sv
hdl/periph_bridge.sv
hdl/soc_top.sv
sim/tb_soc.sv

// File: hdl/bram.sv
`include "soc_defines.svh"

`timescale 1ns/1ps

module bram import soc_pkg::*; #(
	parameter int DEPTH = `RAM_WORDS
) (
	input  logic     i_clock,
	input  bus_req_t i_req,
	output bus_rsp_t o_rsp
);

	localparam int AW = $clog2(DEPTH);

	logic [`SOC_DATA_W-1:0] mem [DEPTH];
	logic [`SOC_DATA_W-1:0] rdata_q;
	logic                   ready_q;
	logic [AW-1:0]          index;
	logic                   take;

	// Word index, byte offset dropped
	assign index = i_req.addr.word[AW+1:2];

	// Held request is only taken once per ready pulse
	assign take = i_req.req && !ready_q;

	always_ff @(posedge i_clock) begin
		ready_q <= take;
		if (take) begin
			if (i_req.rw)
				mem[index] <= i_req.wdata;
			rdata_q <= i_req.rw ? '0 : mem[index];
		end
	end

	assign o_rsp.ready = ready_q;
	assign o_rsp.rdata = rdata_q;

	a_in_range: assert property (@(posedge i_clock)
		take |-> (i_req.addr.word[27:2] < DEPTH));

endmodule

// File: hdl/bus_access.sv
`include "soc_defines.svh"

`timescale 1ns/1ps

module bus_access import soc_pkg::*; (
	input  logic       i_clock,
	input  logic       i_rst,

	input  fetch_req_t i_pa,
	output bus_rsp_t   o_pa,
	input  bus_req_t   i_pb,
	output bus_rsp_t   o_pb,
	input  bus_req_t   i_pc,
	output bus_rsp_t   o_pc,

	output bus_req_t   o_bus,
	input  bus_rsp_t   i_bus,
	output port_id_e   o_grant
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_BUSY,
		ST_RESPOND
	} state_e;

	state_e                 state_q;
	port_id_e               grant_q;
	logic                   req_q;
	logic                   rw_q;
	bus_addr_u              addr_q;
	logic [`SOC_DATA_W-1:0] wdata_q;
	logic [`SOC_DATA_W-1:0] rdata_q;

	port_id_e pick;
	bus_req_t pick_req;

	// Fixed priority, fetch port first
	always_comb begin
		pick = PORT_NONE;
		pick_req = '0;
		if (i_pa.req) begin
			pick = PORT_A;
			pick_req.req = 1'b1;
			pick_req.addr.word = i_pa.addr;
		end else if (i_pb.req) begin
			pick = PORT_B;
			pick_req = i_pb;
		end else if (i_pc.req) begin
			pick = PORT_C;
			pick_req = i_pc;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state_q <= ST_IDLE;
			grant_q <= PORT_NONE;
			req_q <= 1'b0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (pick != PORT_NONE) begin
						state_q <= ST_BUSY;
						grant_q <= pick;
						req_q <= 1'b1;
					end
				end
				ST_BUSY: begin
					if (i_bus.ready) begin
						state_q <= ST_RESPOND;
						req_q <= 1'b0;
					end
				end
				// Bus request stays low here for one cycle
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (state_q == ST_IDLE) begin
			rw_q <= pick_req.rw;
			addr_q <= pick_req.addr;
			wdata_q <= pick_req.wdata;
		end
		if (state_q == ST_BUSY && i_bus.ready)
			rdata_q <= i_bus.rdata;
	end

	always_comb begin
		o_bus.req = req_q;
		o_bus.rw = rw_q;
		o_bus.addr = addr_q;
		o_bus.wdata = wdata_q;
	end

	assign o_grant = grant_q;

	assign o_pa.ready = (state_q == ST_RESPOND) && (grant_q == PORT_A);
	assign o_pb.ready = (state_q == ST_RESPOND) && (grant_q == PORT_B);
	assign o_pc.ready = (state_q == ST_RESPOND) && (grant_q == PORT_C);
	assign o_pa.rdata = rdata_q;
	assign o_pb.rdata = rdata_q;
	assign o_pc.rdata = rdata_q;

	// ====================
	// Checks
	a_one_ready: assert property (@(posedge i_clock) disable iff (i_rst)
		$onehot0({o_pa.ready, o_pb.ready, o_pc.ready}));

	// New bus cycle only starts out of idle
	a_no_overlap: assert property (@(posedge i_clock) disable iff (i_rst)
		$rose(o_bus.req) |-> $past(state_q == ST_IDLE));

endmodule

// File: hdl/led_port.sv
`include "soc_defines.svh"

`timescale 1ns/1ps

module led_port import soc_pkg::*; (
	input  logic              i_clock,
	input  logic              i_rst,
	input  bus_req_t          i_req,
	output bus_rsp_t          o_rsp,
	output logic [`LED_W-1:0] o_led
);

	logic              ready_q;
	logic [`LED_W-1:0] led_q;
	logic              take;

	assign take = i_req.req && !ready_q;

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			ready_q <= 1'b0;
			led_q <= '0;
		end else begin
			ready_q <= take;
			if (take && i_req.rw)
				led_q <= i_req.wdata[`LED_W-1:0];
		end
	end

	// Write only, reads give zero
	assign o_rsp.ready = ready_q;
	assign o_rsp.rdata = '0;
	assign o_led = led_q;

endmodule

// File: hdl/periph_bridge.sv
`include "soc_defines.svh"

`timescale 1ns/1ps

module periph_bridge import soc_pkg::*; (
	input  logic              i_clock,
	input  logic              i_rst,
	input  bus_req_t          i_near,
	output bus_rsp_t          o_near,
	output logic [`LED_W-1:0] o_led,
	output logic              o_timer_irq
);

	logic                   busy_q;
	logic                   far_req_q;
	logic                   near_ready_q;
	logic                   far_rw_q;
	bus_addr_u              far_addr_q;
	logic [`SOC_DATA_W-1:0] far_wdata_q;
	logic [`SOC_DATA_W-1:0] near_rdata_q;
	logic                   miss_ready_q;

	bus_req_t far_bus;
	bus_req_t led_req;
	bus_req_t timer_req;
	bus_rsp_t led_rsp;
	bus_rsp_t timer_rsp;
	bus_rsp_t far_rsp;
	logic     sel_led;
	logic     sel_timer;

	// ====================
	// Near side
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			busy_q <= 1'b0;
			far_req_q <= 1'b0;
			near_ready_q <= 1'b0;
		end else begin
			near_ready_q <= 1'b0;
			if (near_ready_q)
				busy_q <= 1'b0;
			else if (!busy_q && i_near.req) begin
				busy_q <= 1'b1;
				far_req_q <= 1'b1;
			end else if (far_req_q && far_rsp.ready) begin
				far_req_q <= 1'b0;
				near_ready_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (!busy_q && i_near.req) begin
			far_rw_q <= i_near.rw;
			far_addr_q <= i_near.addr;
			far_wdata_q <= i_near.wdata;
		end
		if (far_req_q && far_rsp.ready)
			near_rdata_q <= far_rsp.rdata;
	end

	assign o_near.ready = near_ready_q;
	assign o_near.rdata = near_rdata_q;

	// ====================
	// Far side
	assign far_bus = '{req: far_req_q, rw: far_rw_q, addr: far_addr_q, wdata: far_wdata_q};

	assign sel_led = far_bus.addr.far.device == `DEV_LED;
	assign sel_timer = far_bus.addr.far.device == `DEV_TIMER;

	always_comb begin
		led_req = far_bus;
		led_req.req = far_bus.req && sel_led;
		timer_req = far_bus;
		timer_req.req = far_bus.req && sel_timer;
	end

	// No device behind this code, answer here
	always_ff @(posedge i_clock) begin
		if (i_rst)
			miss_ready_q <= 1'b0;
		else
			miss_ready_q <= far_bus.req && !sel_led && !sel_timer && !miss_ready_q;
	end

	always_comb begin
		if (sel_led)
			far_rsp = led_rsp;
		else if (sel_timer)
			far_rsp = timer_rsp;
		else
			far_rsp = '{ready: miss_ready_q, rdata: '0};
	end

	led_port u_led (
		.i_clock (i_clock),
		.i_rst   (i_rst),
		.i_req   (led_req),
		.o_rsp   (led_rsp),
		.o_led   (o_led)
	);

	timer u_timer (
		.i_clock (i_clock),
		.i_rst   (i_rst),
		.i_req   (timer_req),
		.o_rsp   (timer_rsp),
		.o_irq   (o_timer_irq)
	);

endmodule

// File: hdl/soc_pkg.sv
package soc_pkg;

`include "soc_defines.svh"

	// System view of an address
	typedef struct packed {
		logic [3:0]  region;
		logic [27:0] offset;
	} sys_addr_t;

	// Peripheral view, device in bits 27:24
	typedef struct packed {
		logic [3:0]  region;
		logic [3:0]  device;
		logic [23:0] reg_addr;
	} far_addr_t;

	typedef union packed {
		logic [`SOC_DATA_W-1:0] word;
		sys_addr_t              sys;
		far_addr_t              far;
	} bus_addr_u;

	// Instruction fetch, read only
	typedef struct packed {
		logic                   req;
		logic [`SOC_DATA_W-1:0] addr;
	} fetch_req_t;

	typedef struct packed {
		logic                   req;
		logic                   rw;
		bus_addr_u              addr;
		logic [`SOC_DATA_W-1:0] wdata;
	} bus_req_t;

	typedef struct packed {
		logic                   ready;
		logic [`SOC_DATA_W-1:0] rdata;
	} bus_rsp_t;

	typedef enum logic [1:0] {
		PORT_NONE,
		PORT_A,
		PORT_B,
		PORT_C
	} port_id_e;

	typedef struct packed {
		logic                   active;
		logic [`SOC_DATA_W-1:0] addr;
		port_id_e               port;
	} fault_t;

endpackage

// File: hdl/soc_top.sv
`include "soc_defines.svh"

`timescale 1ns/1ps

module soc_top import soc_pkg::*; (
	input  logic              i_clock,
	input  logic              i_rst,

	// Masters
	input  fetch_req_t        i_pa,
	output bus_rsp_t          o_pa,
	input  bus_req_t          i_pb,
	output bus_rsp_t          o_pb,
	input  bus_req_t          i_pc,
	output bus_rsp_t          o_pc,

	// Peripherals and debug
	output logic [`LED_W-1:0] o_led,
	output logic              o_timer_irq,
	output fault_t            o_fault
);

	bus_req_t sys_req;
	bus_rsp_t sys_rsp;
	port_id_e sys_grant;

	bus_req_t ram_req;
	bus_rsp_t ram_rsp;
	bus_req_t bridge_req;
	bus_rsp_t bridge_rsp;

	// ====================
	// Bus
	bus_access u_bus_access (
		.i_clock (i_clock),
		.i_rst   (i_rst),
		.i_pa    (i_pa),
		.o_pa    (o_pa),
		.i_pb    (i_pb),
		.o_pb    (o_pb),
		.i_pc    (i_pc),
		.o_pc    (o_pc),
		.o_bus   (sys_req),
		.i_bus   (sys_rsp),
		.o_grant (sys_grant)
	);

	system_decode u_system_decode (
		.i_clock  (i_clock),
		.i_rst    (i_rst),
		.i_bus    (sys_req),
		.o_bus    (sys_rsp),
		.i_grant  (sys_grant),
		.o_ram    (ram_req),
		.o_bridge (bridge_req),
		.i_ram    (ram_rsp),
		.i_bridge (bridge_rsp),
		.o_fault  (o_fault)
	);

	// ====================
	// Targets
	bram #(
		.DEPTH(`RAM_WORDS)
	) u_ram (
		.i_clock (i_clock),
		.i_req   (ram_req),
		.o_rsp   (ram_rsp)
	);

	periph_bridge u_bridge (
		.i_clock     (i_clock),
		.i_rst       (i_rst),
		.i_near      (bridge_req),
		.o_near      (bridge_rsp),
		.o_led       (o_led),
		.o_timer_irq (o_timer_irq)
	);

endmodule

// File: hdl/system_decode.sv
`include "soc_defines.svh"

`timescale 1ns/1ps

module system_decode import soc_pkg::*; (
	input  logic     i_clock,
	input  logic     i_rst,

	input  bus_req_t i_bus,
	output bus_rsp_t o_bus,
	input  port_id_e i_grant,

	output bus_req_t o_ram,
	output bus_req_t o_bridge,
	input  bus_rsp_t i_ram,
	input  bus_rsp_t i_bridge,

	output fault_t   o_fault
);

	logic sel_ram;
	logic sel_bridge;
	logic miss_take;

	logic                   miss_ready_q;
	logic                   fault_active_q;
	logic [`SOC_DATA_W-1:0] fault_addr_q;
	port_id_e               fault_port_q;

	assign sel_ram = i_bus.addr.sys.region == `REGION_RAM;
	assign sel_bridge = i_bus.addr.sys.region == `REGION_BRIDGE;

	always_comb begin
		o_ram = i_bus;
		o_ram.req = i_bus.req && sel_ram;
		o_bridge = i_bus;
		o_bridge.req = i_bus.req && sel_bridge;
	end

	// Unmapped region, complete locally with zero data
	assign miss_take = i_bus.req && !sel_ram && !sel_bridge && !miss_ready_q;

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			miss_ready_q <= 1'b0;
			fault_active_q <= 1'b0;
		end else begin
			miss_ready_q <= miss_take;
			if (miss_take)
				fault_active_q <= 1'b1;
			else if (i_bus.req && (sel_ram || sel_bridge))
				fault_active_q <= 1'b0;
		end
	end

	always_ff @(posedge i_clock) begin
		if (miss_take) begin
			fault_addr_q <= i_bus.addr.word;
			fault_port_q <= i_grant;
		end
	end

	always_comb begin
		if (sel_ram)
			o_bus = i_ram;
		else if (sel_bridge)
			o_bus = i_bridge;
		else begin
			o_bus.ready = miss_ready_q;
			o_bus.rdata = '0;
		end
	end

	assign o_fault = '{active: fault_active_q, addr: fault_addr_q, port: fault_port_q};

	a_one_target: assert property (@(posedge i_clock) disable iff (i_rst)
		!(o_ram.req && o_bridge.req));

endmodule

// File: hdl/timer.sv
`include "soc_defines.svh"

`timescale 1ns/1ps

module timer import soc_pkg::*; (
	input  logic     i_clock,
	input  logic     i_rst,
	input  bus_req_t i_req,
	output bus_rsp_t o_rsp,
	output logic     o_irq
);

	localparam int PW = $clog2(`TIMER_PRESCALE);
	localparam logic [PW-1:0] PRE_LAST = PW'(`TIMER_PRESCALE - 1);

	logic [PW-1:0]          pre_q;
	logic [`SOC_DATA_W-1:0] count_q;
	logic [`SOC_DATA_W-1:0] compare_q;
	logic                   enable_q;
	logic                   ready_q;
	logic [`SOC_DATA_W-1:0] rdata_q;
	logic                   take;
	logic                   tick;
	logic [2:0]             reg_sel;

	assign take = i_req.req && !ready_q;
	assign reg_sel = i_req.addr.far.reg_addr[4:2];
	assign tick = enable_q && (pre_q == PRE_LAST);

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			pre_q <= '0;
			count_q <= '0;
			compare_q <= '0;
			enable_q <= 1'b0;
			ready_q <= 1'b0;
		end else begin
			ready_q <= take;
			if (enable_q)
				pre_q <= tick ? '0 : pre_q + 1'b1;
			// Bus write wins over a tick in the same cycle
			if (take && i_req.rw && reg_sel == `TIMER_REG_COUNT)
				count_q <= i_req.wdata;
			else if (tick)
				count_q <= count_q + 1'b1;
			if (take && i_req.rw && reg_sel == `TIMER_REG_COMPARE)
				compare_q <= i_req.wdata;
			if (take && i_req.rw && reg_sel == `TIMER_REG_CTRL)
				enable_q <= i_req.wdata[0];
		end
	end

	always_ff @(posedge i_clock) begin
		if (take) begin
			if (i_req.rw)
				rdata_q <= '0;
			else if (reg_sel == `TIMER_REG_COUNT)
				rdata_q <= count_q;
			else if (reg_sel == `TIMER_REG_COMPARE)
				rdata_q <= compare_q;
			else
				rdata_q <= '0;
		end
	end

	assign o_rsp.ready = ready_q;
	assign o_rsp.rdata = rdata_q;

	// Level interrupt
	assign o_irq = enable_q && (count_q >= compare_q);

endmodule

// File: include/soc_defines.svh
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// Bus geometry
`define SOC_DATA_W 32

// System regions, top address nibble
`define REGION_RAM    4'h1
`define REGION_BRIDGE 4'h5

// Far bus device codes, address bits 27:24
`define DEV_LED   4'h0
`define DEV_TIMER 4'h5

// On-chip RAM depth in words
`define RAM_WORDS 512

`define LED_W 10

// Timer tick every N clocks
`define TIMER_PRESCALE 4
`define TIMER_REG_COUNT   3'd0
`define TIMER_REG_COMPARE 3'd1
`define TIMER_REG_CTRL    3'd2

`endif

// File: run_sim.sh
#!/bin/sh
# Build the SoC bus fabric testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f compile.f --top-module tb_soc \
	-Mdir obj_dir -o tb_soc > "$BUILD_LOG" 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "Verilator build failed with status $build_status"
	exit 1
fi

./obj_dir/tb_soc > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "test failed" "$SIM_LOG"; then
	exit 1
fi
exit 0

// File: sim/soc_tb_tasks.svh
`ifndef SOC_TB_TASKS_SVH
`define SOC_TB_TASKS_SVH

	// ====================
	// Helpers
	function automatic logic [31:0] ram_addr(input int unsigned idx);
		return {`REGION_RAM, 28'(idx << 2)};
	endfunction

	function automatic logic [31:0] timer_addr(input logic [2:0] sel);
		return {`REGION_BRIDGE, `DEV_TIMER, 19'd0, sel, 2'b00};
	endfunction

	task automatic compare_word(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (errors == errs_before) begin
			$display("%s: ok", name);
			pass_count++;
		end else begin
			$display("%s: %0d errors", name, errors - errs_before);
			fail_count++;
		end
	endtask

	// ====================
	// Port drivers

	// Port A is read only
	task automatic fetch_read(input logic [31:0] addr, output logic [31:0] data);
		int waited;
		@(posedge clock);
		pa_req.req <= 1'b1;
		pa_req.addr <= addr;
		waited = 0;
		do begin
			@(posedge clock);
			waited++;
		end while (!pa_rsp.ready && waited < READY_LIMIT);
		data = pa_rsp.rdata;
		ready_cycle_a = cycle_count;
		pa_req.req <= 1'b0;
		if (!pa_rsp.ready) begin
			$display("Port A saw no ready within %0d cycles for address %h", READY_LIMIT, addr);
			errors++;
		end
	endtask

	task automatic data_access(input logic rw, input logic [31:0] addr,
			input logic [31:0] wdata, output logic [31:0] data);
		int waited;
		@(posedge clock);
		pb_req.req <= 1'b1;
		pb_req.rw <= rw;
		pb_req.addr.word <= addr;
		pb_req.wdata <= wdata;
		waited = 0;
		do begin
			@(posedge clock);
			waited++;
		end while (!pb_rsp.ready && waited < READY_LIMIT);
		data = pb_rsp.rdata;
		ready_cycle_b = cycle_count;
		pb_req.req <= 1'b0;
		if (!pb_rsp.ready) begin
			$display("Port B saw no ready within %0d cycles for address %h", READY_LIMIT, addr);
			errors++;
		end
	endtask

	task automatic dma_access(input logic rw, input logic [31:0] addr,
			input logic [31:0] wdata, output logic [31:0] data);
		int waited;
		@(posedge clock);
		pc_req.req <= 1'b1;
		pc_req.rw <= rw;
		pc_req.addr.word <= addr;
		pc_req.wdata <= wdata;
		waited = 0;
		do begin
			@(posedge clock);
			waited++;
		end while (!pc_rsp.ready && waited < READY_LIMIT);
		data = pc_rsp.rdata;
		ready_cycle_c = cycle_count;
		pc_req.req <= 1'b0;
		if (!pc_rsp.ready) begin
			$display("Port C saw no ready within %0d cycles for address %h", READY_LIMIT, addr);
			errors++;
		end
	endtask

	// ====================
	// Directed tests
	task automatic ram_rw_test();
		int errs_before;
		logic [31:0] wd;
		logic [31:0] rd;
		errs_before = errors;
		for (int i = 0; i < 8; i++) begin
			wd = next_rand();
			data_access(1'b1, ram_addr(16 + i * 3), wd, rd);
			ram_model[16 + i * 3] = wd;
			compare_word("o_pb.rdata on write", rd, 32'h0);
		end
		for (int i = 0; i < 8; i++) begin
			data_access(1'b0, ram_addr(16 + i * 3), 32'h0, rd);
			compare_word("o_pb.rdata", rd, ram_model[16 + i * 3]);
		end
		report_test("RAM write and read on port B", errs_before);
	endtask

	// Words written by DMA are fetched by port A
	task automatic cross_port_test();
		int errs_before;
		logic [31:0] wd;
		logic [31:0] rd;
		errs_before = errors;
		for (int i = 0; i < 4; i++) begin
			wd = next_rand();
			dma_access(1'b1, ram_addr(100 + i), wd, rd);
			ram_model[100 + i] = wd;
			compare_word("o_pc.rdata on write", rd, 32'h0);
		end
		for (int i = 0; i < 4; i++) begin
			fetch_read(ram_addr(100 + i), rd);
			compare_word("o_pa.rdata", rd, ram_model[100 + i]);
		end
		report_test("Port C write, port A read", errs_before);
	endtask

	task automatic arbitration_test();
		int errs_before;
		logic [31:0] new_word;
		logic [31:0] rd_a;
		logic [31:0] rd_b;
		logic [31:0] rd_c;
		errs_before = errors;
		for (int i = 0; i < 3; i++) begin
			ram_model[200 + i] = next_rand();
			data_access(1'b1, ram_addr(200 + i), ram_model[200 + i], rd_b);
		end
		new_word = next_rand();
		// All three requests rise on the same edge
		fork
			fetch_read(ram_addr(200), rd_a);
			data_access(1'b1, ram_addr(201), new_word, rd_b);
			dma_access(1'b0, ram_addr(202), 32'h0, rd_c);
		join
		ram_model[201] = new_word;
		compare_word("o_pa.rdata", rd_a, ram_model[200]);
		compare_word("o_pb.rdata on write", rd_b, 32'h0);
		compare_word("o_pc.rdata", rd_c, ram_model[202]);
		if (!(ready_cycle_a < ready_cycle_b && ready_cycle_b < ready_cycle_c)) begin
			$display("Ready order is not A, B, C: A at cycle %0d, B at %0d, C at %0d",
				ready_cycle_a, ready_cycle_b, ready_cycle_c);
			errors++;
		end
		data_access(1'b0, ram_addr(201), 32'h0, rd_b);
		compare_word("o_pb.rdata", rd_b, new_word);
		report_test("Three-port arbitration", errs_before);
	endtask

	task automatic led_test();
		int errs_before;
		logic [31:0] wd;
		logic [31:0] rd;
		errs_before = errors;
		wd = next_rand();
		data_access(1'b1, LED_ADDR, wd, rd);
		compare_word("o_led", 32'(led), 32'(wd[`LED_W-1:0]));
		data_access(1'b0, LED_ADDR, 32'h0, rd);
		compare_word("o_pb.rdata from LED", rd, 32'h0);
		report_test("LED register", errs_before);
	endtask

	task automatic timer_test();
		int errs_before;
		int waited;
		logic [31:0] rd;
		logic [31:0] count_1;
		logic [31:0] count_2;
		errs_before = errors;
		data_access(1'b1, timer_addr(`TIMER_REG_COUNT), 32'h0, rd);
		// Count meets compare here so only the enable keeps the interrupt low
		data_access(1'b1, timer_addr(`TIMER_REG_COMPARE), 32'h0, rd);
		compare_word("o_timer_irq while disabled", 32'(timer_irq), 32'h0);
		data_access(1'b1, timer_addr(`TIMER_REG_COMPARE), 32'd5, rd);
		data_access(1'b1, timer_addr(`TIMER_REG_CTRL), 32'h1, rd);
		waited = 0;
		while (!timer_irq && waited < IRQ_LIMIT) begin
			@(posedge clock);
			waited++;
		end
		if (!timer_irq) begin
			$display("Timer interrupt did not rise within %0d cycles", IRQ_LIMIT);
			errors++;
		end
		data_access(1'b0, timer_addr(`TIMER_REG_COUNT), 32'h0, count_1);
		data_access(1'b0, timer_addr(`TIMER_REG_COUNT), 32'h0, count_2);
		if (count_1 < 32'd5) begin
			$display("Timer count %h is below compare 5 with the interrupt high", count_1);
			errors++;
		end
		if (count_2 < count_1) begin
			$display("Timer count went backwards from %h to %h", count_1, count_2);
			errors++;
		end
		data_access(1'b0, timer_addr(`TIMER_REG_COMPARE), 32'h0, rd);
		compare_word("timer compare readback", rd, 32'd5);
		data_access(1'b1, timer_addr(`TIMER_REG_COMPARE), 32'hffff_0000, rd);
		compare_word("o_timer_irq after large compare", 32'(timer_irq), 32'h0);
		report_test("Timer compare interrupt", errs_before);
	endtask

	task automatic bus_fault_test();
		int errs_before;
		logic [31:0] rd;
		errs_before = errors;
		compare_word("o_fault.active before", 32'(fault.active), 32'h0);
		data_access(1'b0, UNMAPPED_ADDR, 32'h0, rd);
		compare_word("o_pb.rdata from unmapped region", rd, 32'h0);
		compare_word("o_fault.active", 32'(fault.active), 32'h1);
		compare_word("o_fault.addr", fault.addr, UNMAPPED_ADDR);
		compare_word("o_fault.port", 32'(fault.port), 32'(PORT_B));
		// A mapped access clears the fault
		data_access(1'b0, ram_addr(16), 32'h0, rd);
		compare_word("o_pb.rdata", rd, ram_model[16]);
		compare_word("o_fault.active after valid access", 32'(fault.active), 32'h0);
		report_test("Bus fault on unmapped region", errs_before);
	endtask

`endif

// File: sim/tb_soc.sv
`include "soc_defines.svh"

`timescale 1ns/1ps

module tb_soc import soc_pkg::*; ();

	localparam int NUM_TESTS = 6;
	localparam int WATCHDOG_CYCLES = NUM_TESTS * 2000;
	localparam int READY_LIMIT = 100;
	localparam int IRQ_LIMIT = 5 * `TIMER_PRESCALE + 16;
	localparam logic [31:0] LED_ADDR = {`REGION_BRIDGE, `DEV_LED, 24'h0};
	localparam logic [31:0] UNMAPPED_ADDR = 32'h3000_0040;

	logic clock = 1'b0;
	logic rst;

	// Master ports
	fetch_req_t pa_req;
	bus_rsp_t   pa_rsp;
	bus_req_t   pb_req;
	bus_rsp_t   pb_rsp;
	bus_req_t   pc_req;
	bus_rsp_t   pc_rsp;

	logic [`LED_W-1:0] led;
	logic              timer_irq;
	fault_t            fault;

	int errors = 0;
	int pass_count = 0;
	int fail_count = 0;
	int cycle_count = 0;
	int ready_cycle_a = 0;
	int ready_cycle_b = 0;
	int ready_cycle_c = 0;
	logic [31:0] lcg_state = 32'h89a9_cf1c;

	// Expected RAM contents, word index to data
	logic [31:0] ram_model [int unsigned];

	soc_top DUT (
		.i_clock     (clock),
		.i_rst       (rst),
		.i_pa        (pa_req),
		.o_pa        (pa_rsp),
		.i_pb        (pb_req),
		.o_pb        (pb_rsp),
		.i_pc        (pc_req),
		.o_pc        (pc_rsp),
		.o_led       (led),
		.o_timer_irq (timer_irq),
		.o_fault     (fault)
	);

	// ====================
	// Clock and cycle count
	always #5 clock = ~clock;

	always @(posedge clock)
		cycle_count <= cycle_count + 1;

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	`include "soc_tb_tasks.svh"

	// ====================
	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("Watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
		$display("test failed");
		$finish;
	end

	// ====================
	// Sequence
	initial begin
		rst <= 1'b1;
		pa_req <= '0;
		pb_req <= '0;
		pc_req <= '0;
		repeat (10) @(posedge clock);
		rst <= 1'b0;
		repeat (2) @(posedge clock);

		ram_rw_test();
		cross_port_test();
		arbitration_test();
		led_test();
		timer_test();
		bus_fault_test();

		$display("Summary: %0d ok, %0d with errors, %0d errors in all",
			pass_count, fail_count, errors);
		if (fail_count == 0 && errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule
